// File: list.f
+incdir+hdl
hdl/btb_pkg.sv
hdl/entry_sweep_counter.sv
hdl/btb_ctrl_fsm.sv
hdl/branch_target_buff.sv
hdl/fetch_lookup_stage.sv
hdl/btb_top.sv
dv/btb_tb.sv

// File: Makefile
# Verilator build and run for the BTB testbench

VERILATOR ?= verilator
TOP       ?= btb_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Test OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell find hdl dv -name '*.sv' -o -name '*.svh')
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the output is kept in a shell variable and searched for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

// File: dv/btb_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "btb_macros.svh"

module btb_tb
    import btb_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int SWEEP_CYCLES   = `BTB_ENTRIES;  // one valid bit cleared per edge
    localparam int SEED           = 32'h2427e80d;

    logic      clk;
    logic      rst_n;
    logic      flush;
    logic      req_valid;
    logic      req_ready;
    btb_req_t  req;
    logic      resp_valid;
    logic      resp_ready;
    btb_pred_t resp;
    logic      upd_valid;
    logic      upd_ready;
    btb_upd_t  upd;

    // reference model of the 64 entries
    logic      m_valid  [`BTB_ENTRIES];
    btb_tag_t  m_tag    [`BTB_ENTRIES];
    addr_t     m_target [`BTB_ENTRIES];
    addr_t     m_fip_e  [`BTB_ENTRIES];
    addr_t     m_fip_o  [`BTB_ENTRIES];

    btb_pred_t  exp_mem [256];  // expected predictions in request order
    logic [7:0] wr_ptr;
    logic [7:0] rd_ptr;
    logic [7:0] pending;
    btb_pred_t  exp_head;

    int    sweep_left  = SWEEP_CYCLES; // edges until the ports are ready again
    logic  booting     = 1'b1;
    int    cycle_count = 0;
    int    seed;
    int    bp_seed;
    int    bp_rnd;
    int    rr_mode;                    // 0 always ready, 1 random, 2 held low
    int    error_count = 0;
    int    errors_at_start;
    int    tests_passed = 0;
    int    tests_failed = 0;
    string test_name;
    addr_t installed[$];
    addr_t old_eip;
    addr_t new_eip;
    logic [31:0] pick;
    int    sel;

    btb_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .upd_valid  (upd_valid),
        .upd_ready  (upd_ready),
        .upd        (upd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign pending  = wr_ptr - rd_ptr;
    assign exp_head = exp_mem[rd_ptr];

    // hit needs a valid line at the low EIP bits with matching upper bits
    function automatic btb_pred_t predict_lookup(input addr_t eip);
        btb_pred_t  p;
        btb_index_t idx;
        idx      = eip[`BTB_INDEX_BITS-1:0];
        p.hit    = m_valid[idx] && (m_tag[idx] == eip[`BTB_ADDR_BITS-1:`BTB_INDEX_BITS]);
        p.target = m_target[idx];
        p.fip_e  = m_fip_e[idx];
        p.fip_o  = m_fip_o[idx];
        return p;
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!rst_n) begin
            sweep_left <= SWEEP_CYCLES;
            booting    <= 1'b1;
            wr_ptr     <= 8'd0;
            rd_ptr     <= 8'd0;
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                m_valid[i] = 1'b0;
            end
        end else begin
            if (sweep_left != 0) begin
                sweep_left <= sweep_left - 1;
                if (sweep_left == 1) begin
                    booting <= 1'b0;
                end
            end else if (flush) begin
                sweep_left <= SWEEP_CYCLES;
            end
            if (req_valid && req_ready) begin
                exp_mem[wr_ptr] <= predict_lookup(req.eip); // contents before this edge
                wr_ptr          <= wr_ptr + 8'd1;
            end
            if (resp_valid && resp_ready && pending != 8'd0) begin
                rd_ptr <= rd_ptr + 8'd1;
            end
            if (upd_valid && upd_ready) begin
                m_valid[upd.eip[`BTB_INDEX_BITS-1:0]]  = 1'b1;
                m_tag[upd.eip[`BTB_INDEX_BITS-1:0]]    = upd.eip[`BTB_ADDR_BITS-1:`BTB_INDEX_BITS];
                m_target[upd.eip[`BTB_INDEX_BITS-1:0]] = upd.target;
                m_fip_e[upd.eip[`BTB_INDEX_BITS-1:0]]  = upd.fip_e;
                m_fip_o[upd.eip[`BTB_INDEX_BITS-1:0]]  = upd.fip_o;
            end
            if (sweep_left == 0 && flush) begin
                for (int i = 0; i < `BTB_ENTRIES; i++) begin
                    m_valid[i] = 1'b0;
                end
            end
        end
    end

    reset_quiet: assert property (@(posedge clk)
        (cycle_count != 0 && !rst_n) |-> (!req_ready && !upd_ready && !resp_valid))
        else begin
            $display("%s: a ready or resp_valid was high while rst_n was low", test_name);
            error_count++;
        end

    upd_ready_timing: assert property (@(posedge clk)
        rst_n |-> (upd_ready == (sweep_left == 0)))
        else begin
            $display("CHECK FAILED %s: upd_ready expected %0b actual %0b",
                     test_name, $sampled(sweep_left) == 0, $sampled(upd_ready));
            error_count++;
        end

    req_ready_rule: assert property (@(posedge clk)
        rst_n |-> (req_ready == ((sweep_left == 0) && (!resp_valid || resp_ready))))
        else begin
            $display("CHECK FAILED %s: req_ready expected %0b actual %0b", test_name,
                     ($sampled(sweep_left) == 0) &&
                     (!$sampled(resp_valid) || $sampled(resp_ready)),
                     $sampled(req_ready));
            error_count++;
        end

    boot_no_resp: assert property (@(posedge clk) (rst_n && booting) |-> !resp_valid)
        else begin
            $display("%s: resp_valid rose before the reset sweep ended", test_name);
            error_count++;
        end

    resp_held: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp)))
        else begin
            $display("%s: response changed or vanished before it was taken", test_name);
            error_count++;
        end

    resp_expected: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_valid && resp_ready) |-> (pending != 8'd0))
        else begin
            $display("%s: response delivered with no request outstanding", test_name);
            error_count++;
        end

    resp_hit: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_valid && resp_ready && pending != 8'd0) |-> (resp.hit == exp_head.hit))
        else begin
            $display("CHECK FAILED %s: hit expected %0b actual %0b",
                     test_name, $sampled(exp_head.hit), $sampled(resp.hit));
            error_count++;
        end

    resp_fields: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_valid && resp_ready && pending != 8'd0 && exp_head.hit) |->
        (resp[95:0] == exp_head[95:0]))
        else begin
            $display("CHECK FAILED %s: target/fip_e/fip_o expected %h actual %h",
                     test_name, $sampled(exp_head[95:0]), $sampled(resp[95:0]));
            error_count++;
        end

    // fetch side back-pressure
    initial begin
        resp_ready = 1'b1;
        forever begin
            @(posedge clk);
            bp_rnd = $random(bp_seed);
            case (rr_mode)
                1:       resp_ready <= bp_rnd[0] & bp_rnd[1];
                2:       resp_ready <= 1'b0;
                default: resp_ready <= 1'b1;
            endcase
        end
    end

    task automatic send_lookup(input addr_t eip);
        req_valid <= 1'b1;
        req       <= eip;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic send_update(input addr_t eip, input addr_t target,
                               input addr_t fip_e, input addr_t fip_o);
        upd_valid <= 1'b1;
        upd       <= {eip, target, fip_e, fip_o};
        @(posedge clk);
        while (!upd_ready) @(posedge clk);
        upd_valid <= 1'b0;
    endtask

    task automatic install_random();
        addr_t eip;
        eip = $random(seed);
        send_update(eip, $random(seed), $random(seed), $random(seed));
        installed.push_back(eip);
    endtask

    task automatic pulse_flush();
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic wait_run();
        @(posedge clk);
        while (!upd_ready) @(posedge clk);
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    // every outstanding response must come back before the verdict
    task automatic end_test();
        while (pending != 8'd0) @(posedge clk);
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("test %-14s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %-14s failed with %0d errors", test_name,
                     error_count - errors_at_start);
        end
    endtask

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run stopped after %0d cycles in test %s", cycle_count, test_name);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        seed      = SEED;
        bp_seed   = SEED;
        rr_mode   = 0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        upd_valid = 1'b0;
        upd       = '0;

        begin_test("reset_ready");
        repeat (4) @(posedge clk);
        rst_n     <= 1'b1;
        req_valid <= 1'b1;          // waits through the sweep, taken on the first ready edge
        req       <= 32'h0000_1000;
        wait_run();
        req_valid <= 1'b0;
        end_test();

        begin_test("cold_miss");
        repeat (50) send_lookup($random(seed));
        end_test();

        begin_test("install_hit");
        repeat (16) install_random();
        foreach (installed[i]) send_lookup(installed[i]);
        end_test();

        begin_test("alias_replace");
        old_eip = installed[installed.size()-1];
        new_eip = old_eip ^ 32'h0000_1040; // same index but a different tag
        send_lookup(old_eip);
        send_lookup(new_eip);
        send_update(new_eip, $random(seed), $random(seed), $random(seed));
        installed.push_back(new_eip);
        send_lookup(old_eip);
        send_lookup(new_eip);
        end_test();

        begin_test("back_pressure");
        rr_mode = 1;
        repeat (80) begin
            pick = $random(seed);
            sel  = int'(pick[31:8]) % installed.size();
            case (pick[1:0])
                2'd0:    install_random();
                2'd1:    send_lookup($random(seed));
                default: send_lookup(installed[sel]);
            endcase
        end
        end_test();
        rr_mode = 0;

        begin_test("flush");
        rr_mode = 2;
        send_lookup(installed[0]);  // still held when the sweep starts
        pulse_flush();
        rr_mode = 0;
        wait_run();
        foreach (installed[i]) send_lookup(installed[i]);
        installed.delete();
        repeat (8) install_random();
        foreach (installed[i]) send_lookup(installed[i]);
        end_test();

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/btb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "btb_macros.svh"

module btb_top
    import btb_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,      // context switch pulse

    // lookup request
    input  logic      req_valid,
    output logic      req_ready,
    input  btb_req_t  req,

    // prediction response
    output logic      resp_valid,
    input  logic      resp_ready,
    output btb_pred_t resp,

    // update from writeback
    input  logic      upd_valid,
    output logic      upd_ready,
    input  btb_upd_t  upd
);

    logic       sweep;
    logic       start;
    logic       run;
    logic       last;
    btb_index_t sweep_index;

    btb_index_t lookup_index;
    btb_tag_t   lookup_tag;
    btb_pred_t  lookup_pred;

    logic       upd_fire;
    logic       wr_en;
    logic       wr_valid;
    btb_index_t wr_index;

    btb_ctrl_fsm u_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .last  (last),
        .sweep (sweep),
        .start (start),
        .run   (run)
    );

    entry_sweep_counter u_sweep_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .sweep (sweep),
        .start (start),
        .index (sweep_index),
        .last  (last)
    );

    assign upd_ready = run;
    assign upd_fire  = upd_valid & upd_ready;

    // sweep owns the write port, updates only get it in run
    assign wr_en    = sweep | upd_fire;
    assign wr_valid = ~sweep;
    assign wr_index = sweep ? sweep_index : upd.eip[`BTB_INDEX_BITS-1:0];

    branch_target_buff u_btb (
        .clk          (clk),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .lookup_pred  (lookup_pred),
        .wr_en        (wr_en),
        .wr_valid     (wr_valid),
        .wr_index     (wr_index),
        .wr_data      (upd)
    );

    fetch_lookup_stage u_lookup (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .lookup_pred  (lookup_pred),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp         (resp)
    );

endmodule

`default_nettype wire

// File: hdl/fetch_lookup_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "btb_macros.svh"

module fetch_lookup_stage
    import btb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,          // low while the valid sweep runs

    // lookup request from fetch
    input  logic       req_valid,
    output logic       req_ready,
    input  btb_req_t   req,

    // to and from the storage
    output btb_index_t lookup_index,
    output btb_tag_t   lookup_tag,
    input  btb_pred_t  lookup_pred,

    // registered prediction back to fetch
    output logic       resp_valid,
    input  logic       resp_ready,
    output btb_pred_t  resp
);

    logic req_fire;

    // split the fetch EIP
    assign lookup_index = req.eip[`BTB_INDEX_BITS-1:0];
    assign lookup_tag   = req.eip[`BTB_ADDR_BITS-1:`BTB_INDEX_BITS];

    // take a new request only when the output slot is free or draining
    assign req_ready = run & (~resp_valid | resp_ready);
    assign req_fire  = req_valid & req_ready;

    // Not cleared by a flush: a response captured before the sweep
    // started is still handed to fetch.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else if (req_fire) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    // storage contents before this edge are what gets captured
    always_ff @(posedge clk) begin
        if (req_fire) begin
            resp <= lookup_pred;
        end
    end

endmodule

`default_nettype wire

// File: hdl/branch_target_buff.sv
`timescale 1ns/1ps
`default_nettype none

`include "btb_macros.svh"

module branch_target_buff
    import btb_pkg::*;
(
    input  logic       clk,

    // lookup side, combinational
    input  btb_index_t lookup_index,
    input  btb_tag_t   lookup_tag,
    output btb_pred_t  lookup_pred,

    // single write port, shared by sweep clears and updates
    input  logic       wr_en,
    input  logic       wr_valid,   // low for a sweep clear
    input  btb_index_t wr_index,
    input  btb_upd_t   wr_data
);

    // an entry is a 26 bit tag plus target, FIP_E and FIP_O
    btb_tag_t tag_mem    [`BTB_ENTRIES];
    addr_t    target_mem [`BTB_ENTRIES];
    addr_t    fip_e_mem  [`BTB_ENTRIES];
    addr_t    fip_o_mem  [`BTB_ENTRIES];
    logic     valid_mem  [`BTB_ENTRIES];

    btb_tag_t wr_tag;

    btb_tag_t rd_tag;
    logic     rd_valid;
    addr_t    rd_target;
    addr_t    rd_fip_e;
    addr_t    rd_fip_o;

    // the index half of the EIP is carried separately on wr_index
    assign wr_tag = wr_data.eip[`BTB_ADDR_BITS-1:`BTB_INDEX_BITS];

    // valid bits, cleared one line per cycle by the sweep
    always_ff @(posedge clk) begin
        if (wr_en) begin
            valid_mem[wr_index] <= wr_valid;
        end
    end

    // payload only changes on a real install
    always_ff @(posedge clk) begin
        if (wr_en && wr_valid) begin
            tag_mem[wr_index]    <= wr_tag;
            target_mem[wr_index] <= wr_data.target;
            fip_e_mem[wr_index]  <= wr_data.fip_e;
            fip_o_mem[wr_index]  <= wr_data.fip_o;
        end
    end

    // read the indexed line
    always_comb begin
        rd_valid  = valid_mem[lookup_index];
        rd_tag    = tag_mem[lookup_index];
        rd_target = target_mem[lookup_index];
        rd_fip_e  = fip_e_mem[lookup_index];
        rd_fip_o  = fip_o_mem[lookup_index];
    end

    // Direct mapped, so only one tag compare is needed. The target fields
    // go out regardless of hit; fetch looks at them only on a hit.
    always_comb begin
        lookup_pred.hit    = rd_valid && (rd_tag == lookup_tag);
        lookup_pred.target = rd_target;
        lookup_pred.fip_e  = rd_fip_e;
        lookup_pred.fip_o  = rd_fip_o;
    end

endmodule

`default_nettype wire

// File: hdl/btb_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module btb_ctrl_fsm
    import btb_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic flush, // context switch, one cycle pulse
    input  logic last,  // sweep counter at the final entry
    output logic sweep,
    output logic start,
    output logic run
);

    btb_state_e state;
    btb_state_e state_next;

    // Reset lands in the sweep state, so a reset and a flush clear the
    // valid array through the same path.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= BTB_SWEEP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            BTB_RUN: begin
                if (flush) begin
                    state_next = BTB_SWEEP;
                end
            end
            BTB_SWEEP: begin
                if (last) begin
                    state_next = BTB_RUN; // entry 63 cleared on this edge
                end
            end
            default: begin
                state_next = BTB_SWEEP;
            end
        endcase
    end

    assign run   = (state == BTB_RUN);
    assign sweep = (state == BTB_SWEEP);

    // flush during a sweep is dropped, the sweep already covers it
    assign start = run & flush;

endmodule

`default_nettype wire

// File: hdl/entry_sweep_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "btb_macros.svh"

module entry_sweep_counter
    import btb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sweep,  // advance one entry per cycle
    input  logic       start,  // restart from entry 0
    output btb_index_t index,
    output logic       last
);

    localparam btb_index_t LAST_INDEX = btb_index_t'(`BTB_ENTRIES - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index <= '0;
        end else if (start) begin
            index <= '0;
        end else if (sweep) begin
            index <= index + 1'b1; // wraps back to 0 after the last entry
        end
    end

    // the edge that clears this entry ends the sweep
    assign last = (index == LAST_INDEX);

endmodule

`default_nettype wire

// File: hdl/btb_pkg.sv
`default_nettype none

`include "btb_macros.svh"

package btb_pkg;

    typedef logic [`BTB_ADDR_BITS-1:0]  addr_t;      // instruction address
    typedef logic [`BTB_INDEX_BITS-1:0] btb_index_t; // entry index, low EIP bits
    typedef logic [`BTB_TAG_BITS-1:0]   btb_tag_t;   // upper EIP bits

    // fetch side lookup request
    typedef struct packed {
        addr_t eip;
    } btb_req_t;

    // resolved branch from writeback
    typedef struct packed {
        addr_t eip;
        addr_t target;
        addr_t fip_e;
        addr_t fip_o;
    } btb_upd_t;

    // prediction returned to fetch, target fields only meaningful on hit
    typedef struct packed {
        logic  hit;
        addr_t target;
        addr_t fip_e;
        addr_t fip_o;
    } btb_pred_t;

    typedef enum logic {
        BTB_SWEEP = 1'b0, // clearing valid bits, ports not ready
        BTB_RUN   = 1'b1  // normal lookups and updates
    } btb_state_e;

endpackage

`default_nettype wire

// File: hdl/btb_macros.svh
`ifndef BTB_MACROS_SVH
`define BTB_MACROS_SVH

// width of an EIP, a branch target or a FIP
`define BTB_ADDR_BITS 32

// direct mapped, so the index is the low EIP bits
`define BTB_INDEX_BITS 6

// tag is whatever the index leaves of the EIP
`define BTB_TAG_BITS (`BTB_ADDR_BITS - `BTB_INDEX_BITS)

// one entry per index value
`define BTB_ENTRIES (1 << `BTB_INDEX_BITS)

`endif
